/* hdl/trs_io_pkg.sv */
`default_nettype none

package trs_io_pkg;

  typedef logic [7:0] byte_t;  // spi and data byte

  // command codes sent by the esp
  typedef enum logic [7:0] {
    get_cookie       = 8'd0,
    get_version      = 8'd15,
    set_screen_color = 8'd17,
    send_keyb        = 8'd19,
    z80_dsp_set_addr = 8'd23,
    z80_dsp_poke     = 8'd24,
    z80_dsp_peek     = 8'd25,
    set_led          = 8'd26,
    set_esp_status   = 8'd32
  } cmd_t;

  localparam int max_params = 3;  // set_screen_color carries the most
  typedef logic [1:0] param_idx_t;

  // fixed answers
  localparam byte_t      cookie        = 8'haf;
  localparam logic [2:0] version_major = 3'd0;
  localparam logic [4:0] version_minor = 5'd3;

  localparam int keyb_rows = 8;  // 8x8 matrix

  typedef logic [23:0] rgb_t;  // r in the top byte

  // 2k display ram by default
  localparam int dsp_addr_w = 11;

endpackage

`default_nettype wire

/* hdl/spi_slave.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_slave (
  input  wire logic              clk,
  input  wire logic              cass_out_sel_n,
  input  wire logic              sck,
  input  wire logic              cs_n,
  input  wire logic              mosi,
  input  wire trs_io_pkg::byte_t tx_byte,
  output trs_io_pkg::byte_t      rx_byte,
  output logic                   rx_valid,
  output logic                   miso
);
  import trs_io_pkg::*;

  logic [2:0] sck_sync;   // [0] may be metastable
  logic [2:0] cs_sync;
  logic [1:0] mosi_sync;
  logic       sck_rise;
  logic       cs_active;
  logic       cs_fall;    // start of a frame
  logic [2:0] bit_cnt;
  byte_t      shift_q;

  assign sck_rise  = (sck_sync[2:1] == 2'b01);
  assign cs_active = ~cs_sync[1];
  assign cs_fall   = (cs_sync[2:1] == 2'b10);

  // synchronisers, bit counter and byte strobe
  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      sck_sync  <= 3'b000;
      cs_sync   <= 3'b111;  // deselected
      mosi_sync <= 2'b00;
      bit_cnt   <= 3'd0;
      rx_valid  <= 1'b0;
    end else begin
      sck_sync  <= {sck_sync[1:0], sck};
      cs_sync   <= {cs_sync[1:0], cs_n};
      mosi_sync <= {mosi_sync[0], mosi};
      if (!cs_active) begin
        bit_cnt <= 3'd0;  // frame aborted or idle
      end else if (sck_rise) begin
        bit_cnt <= bit_cnt + 3'd1;  // wraps after bit 7
      end
      // eighth bit of a byte just shifted in
      rx_valid <= cs_active && sck_rise && (bit_cnt == 3'd7);
    end
  end

  // receive shift register, msb first
  always_ff @(posedge clk) begin
    if (cs_fall) begin
      shift_q <= 8'h00;
    end else if (cs_active && sck_rise) begin
      shift_q <= {shift_q[6:0], mosi_sync[1]};
    end
  end

  assign rx_byte = shift_q;  // complete while rx_valid is high

  // next bit shows up once the rising edge has been counted
  assign miso = cs_n ? 1'b0 : tx_byte[3'd7 - bit_cnt];

endmodule

`default_nettype wire

/* hdl/cmd_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_decode (
  input  wire logic              clk,
  input  wire logic              cass_out_sel_n,
  input  wire logic              cs_n,
  input  wire trs_io_pkg::byte_t rx_byte,
  input  wire logic              rx_valid,
  input  wire logic              reply_busy,
  output trs_io_pkg::cmd_t       cmd,
  output trs_io_pkg::byte_t      param0,
  output trs_io_pkg::byte_t      param1,
  output trs_io_pkg::byte_t      param2,
  output logic                   action,
  output logic                   cmd_error
);
  import trs_io_pkg::*;

  typedef enum logic {
    idle,
    read_params
  } state_t;

  state_t     state;
  logic [1:0] cs_sync;
  param_idx_t idx;       // next parameter slot
  param_idx_t remain;    // parameters still to come
  param_idx_t n_params;
  logic       known;
  logic       take;
  byte_t      params [max_params];

  // reply slot bytes are dropped here
  assign take = rx_valid & ~reply_busy & ~cs_sync[1];

  // parameter count per command code
  always_comb begin
    known = 1'b1;
    case (cmd_t'(rx_byte))
      set_screen_color:                      n_params = 2'd3;
      send_keyb, z80_dsp_set_addr:           n_params = 2'd2;
      z80_dsp_poke, set_led, set_esp_status: n_params = 2'd1;
      get_cookie, get_version, z80_dsp_peek: n_params = 2'd0;
      default: begin
        n_params = 2'd0;
        known    = 1'b0;  // unknown code
      end
    endcase
  end

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      state     <= idle;
      cs_sync   <= 2'b11;
      idx       <= '0;
      remain    <= '0;
      action    <= 1'b0;
      cmd_error <= 1'b0;
    end else begin
      cs_sync <= {cs_sync[0], cs_n};
      action  <= 1'b0;  // single cycle strobe
      if (cs_sync[1]) begin
        state <= idle;  // deselect ends any half-read command
      end else if (take) begin
        if (state == idle) begin
          idx    <= '0;
          remain <= n_params;
          if (!known) begin
            cmd_error <= 1'b1;  // sticky until reset
          end else if (n_params == 2'd0) begin
            action <= 1'b1;
          end else begin
            state <= read_params;
          end
        end else begin
          idx    <= idx + 2'd1;
          remain <= remain - 2'd1;
          if (remain == 2'd1) begin
            action <= 1'b1;  // last parameter in
            state  <= idle;
          end
        end
      end
    end
  end

  // command and parameter bytes
  always_ff @(posedge clk) begin
    if (take && state == idle) cmd <= cmd_t'(rx_byte);
    if (take && state == read_params) params[idx] <= rx_byte;
  end

  assign param0 = params[0];
  assign param1 = params[1];
  assign param2 = params[2];

endmodule

`default_nettype wire

/* hdl/cmd_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_execute #(
  parameter int addr_w = 11
) (
  input  wire logic              clk,
  input  wire logic              cass_out_sel_n,
  input  wire trs_io_pkg::cmd_t  cmd,
  input  wire trs_io_pkg::byte_t param0,
  input  wire trs_io_pkg::byte_t param1,
  input  wire trs_io_pkg::byte_t param2,
  input  wire logic              action,
  output logic                   led_red,
  output logic                   led_green,
  output logic                   led_blue,
  output trs_io_pkg::byte_t      esp_status,
  output logic                   keyb_pressed,
  output trs_io_pkg::rgb_t       rgb,
  output trs_io_pkg::byte_t      dsp_rdata,
  output logic                   dsp_rdata_valid
);
  import trs_io_pkg::*;

  localparam int row_w = $clog2(keyb_rows);

  byte_t              keyb_row [keyb_rows];
  byte_t              dsp_ram [2**addr_w];
  byte_t              ram_q;       // raw ram output
  logic [addr_w-1:0]  dsp_addr;
  logic [15:0]        addr_full;
  logic               do_poke;
  logic               do_peek;
  logic               peek_d1;

  assign addr_full = {param1, param0};  // little endian address
  assign do_poke   = action && (cmd == z80_dsp_poke);
  assign do_peek   = action && (cmd == z80_dsp_peek);

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      led_red         <= 1'b0;
      led_green       <= 1'b0;
      led_blue        <= 1'b0;
      esp_status      <= 8'h00;
      rgb             <= 24'h000000;
      dsp_addr        <= '0;
      peek_d1         <= 1'b0;
      dsp_rdata_valid <= 1'b0;
      for (int r = 0; r < keyb_rows; r++) keyb_row[r] <= 8'h00;
    end else begin
      peek_d1         <= do_peek;
      dsp_rdata_valid <= peek_d1;  // 2 clk after action
      if (action && cmd == set_led) begin
        led_red   <= param0[0];
        led_green <= param0[1];
        led_blue  <= param0[2];
      end
      if (action && cmd == set_esp_status) esp_status <= param0;
      if (action && cmd == send_keyb) keyb_row[param0[row_w-1:0]] <= param1;
      if (action && cmd == set_screen_color) rgb <= {param0, param1, param2};
      if (action && cmd == z80_dsp_set_addr) begin
        dsp_addr <= addr_full[addr_w-1:0];
      end else if (do_poke || do_peek) begin
        dsp_addr <= dsp_addr + 1'b1;  // auto increment
      end
    end
  end

  // any key down in any row
  always_comb begin
    keyb_pressed = 1'b0;
    for (int r = 0; r < keyb_rows; r++) keyb_pressed = keyb_pressed | (|keyb_row[r]);
  end

  // display ram, synchronous read
  always_ff @(posedge clk) begin
    if (do_poke) dsp_ram[dsp_addr] <= param0;
    ram_q <= dsp_ram[dsp_addr];
    if (peek_d1) dsp_rdata <= ram_q;
  end

endmodule

`default_nettype wire

/* hdl/reply_select.sv */
`timescale 1ns/1ps
`default_nettype none

module reply_select (
  input  wire logic              clk,
  input  wire logic              cass_out_sel_n,
  input  wire trs_io_pkg::cmd_t  cmd,
  input  wire logic              action,
  input  wire trs_io_pkg::byte_t dsp_rdata,
  input  wire logic              dsp_rdata_valid,
  input  wire logic              rx_valid,
  output trs_io_pkg::byte_t      tx_byte,
  output logic                   reply_busy
);
  import trs_io_pkg::*;

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      tx_byte    <= 8'h00;
      reply_busy <= 1'b0;
    end else if (action && cmd == get_cookie) begin
      tx_byte    <= cookie;
      reply_busy <= 1'b1;
    end else if (action && cmd == get_version) begin
      tx_byte    <= {version_major, version_minor};
      reply_busy <= 1'b1;
    end else if (dsp_rdata_valid) begin
      tx_byte    <= dsp_rdata;  // peek result
      reply_busy <= 1'b1;
    end else if (rx_valid && reply_busy) begin
      // dummy byte done, slot closed
      tx_byte    <= 8'h00;
      reply_busy <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* hdl/trs_io_spi.sv */
`timescale 1ns/1ps
`default_nettype none

module trs_io_spi #(
  parameter int addr_w = trs_io_pkg::dsp_addr_w
) (
  input  wire logic              clk,
  input  wire logic              cass_out_sel_n,
  input  wire logic              sck,
  input  wire logic              cs_n,
  input  wire logic              mosi,
  output wire logic              miso,
  output wire logic              led_red,
  output wire logic              led_green,
  output wire logic              led_blue,
  output wire logic              led_error,
  output wire trs_io_pkg::byte_t esp_status,
  output wire logic              keyb_pressed,
  output wire trs_io_pkg::rgb_t  rgb
);
  import trs_io_pkg::*;

  wire byte_t rx_byte;
  wire logic  rx_valid;
  wire byte_t tx_byte;
  wire logic  reply_busy;
  wire cmd_t  cmd;
  wire byte_t param0;
  wire byte_t param1;
  wire byte_t param2;
  wire logic  action;        // complete command strobe
  wire byte_t dsp_rdata;
  wire logic  dsp_rdata_valid;

  spi_slave spi_slave_i (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .sck            (sck),
    .cs_n           (cs_n),
    .mosi           (mosi),
    .tx_byte        (tx_byte),
    .rx_byte        (rx_byte),
    .rx_valid       (rx_valid),
    .miso           (miso)
  );

  cmd_decode cmd_decode_i (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .cs_n           (cs_n),
    .rx_byte        (rx_byte),
    .rx_valid       (rx_valid),
    .reply_busy     (reply_busy),
    .cmd            (cmd),
    .param0         (param0),
    .param1         (param1),
    .param2         (param2),
    .action         (action),
    .cmd_error      (led_error)  // sticky unknown code
  );

  cmd_execute #(
    .addr_w (addr_w)
  ) cmd_execute_i (
    .clk             (clk),
    .cass_out_sel_n  (cass_out_sel_n),
    .cmd             (cmd),
    .param0          (param0),
    .param1          (param1),
    .param2          (param2),
    .action          (action),
    .led_red         (led_red),
    .led_green       (led_green),
    .led_blue        (led_blue),
    .esp_status      (esp_status),
    .keyb_pressed    (keyb_pressed),
    .rgb             (rgb),
    .dsp_rdata       (dsp_rdata),
    .dsp_rdata_valid (dsp_rdata_valid)
  );

  reply_select reply_select_i (
    .clk             (clk),
    .cass_out_sel_n  (cass_out_sel_n),
    .cmd             (cmd),
    .action          (action),
    .dsp_rdata       (dsp_rdata),
    .dsp_rdata_valid (dsp_rdata_valid),
    .rx_valid        (rx_valid),
    .tx_byte         (tx_byte),
    .reply_busy      (reply_busy)
  );

endmodule

`default_nettype wire

/* tests/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int period_ns    = 100,
  parameter int reset_cycles = 2
) (
  output logic clk,
  output logic cass_out_sel_n
);

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

  initial begin
    cass_out_sel_n = 1'b0;  // held from time zero
    repeat (reset_cycles) @(posedge clk);
    #1 cass_out_sel_n = 1'b1;  // released off the edge
  end

endmodule

`default_nettype wire

/* tests/trs_io_spi_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module trs_io_spi_assert (
  input wire logic clk,
  input wire logic cass_out_sel_n,
  input wire logic action,
  input wire logic reply_busy,
  input wire logic cmd_error,
  input wire logic cs_n,
  input wire logic miso
);

  // one strobe per complete command
  action_single: assert property (@(posedge clk) disable iff (!cass_out_sel_n)
    action |=> !action) else $error("action high for two clocks in a row");

  // unknown codes are only seen outside a reply slot
  error_no_reply: assert property (@(posedge clk) disable iff (!cass_out_sel_n)
    $rose(cmd_error) |-> !$past(reply_busy))
    else $error("cmd_error set during a reply slot");

  miso_quiet: assert property (@(posedge clk) disable iff (!cass_out_sel_n)
    cs_n |-> !miso) else $error("miso driven while cs_n is high");

endmodule

bind trs_io_spi trs_io_spi_assert trs_io_spi_assert_i (
  .clk            (clk),
  .cass_out_sel_n (cass_out_sel_n),
  .action         (action),
  .reply_busy     (reply_busy),
  .cmd_error      (led_error),
  .cs_n           (cs_n),
  .miso           (miso)
);

`default_nettype wire

/* tests/tb_trs_io_spi.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_trs_io_spi;
  import trs_io_pkg::*;

  localparam int addr_w   = trs_io_pkg::dsp_addr_w;
  localparam int half_clk = 8;   // sck half period in clk
  localparam int byte_gap = 16;  // idle clk after each byte
  // worst case bytes over tests 1 to 6
  localparam int total_bytes = 4 + 20 * 4 + 24 * 3 + 70 + 5 + 9;
  localparam int max_cycles  = 2 * total_bytes * 200;

  wire logic  clk;
  wire logic  cass_out_sel_n;
  logic       sck;
  logic       cs_n;
  logic       mosi;
  wire logic  miso;
  wire logic  led_red;
  wire logic  led_green;
  wire logic  led_blue;
  wire logic  led_error;
  wire byte_t esp_status;
  wire logic  keyb_pressed;
  wire rgb_t  rgb;

  int seed      = 32'hfa2c;
  int errors    = 0;
  int checks    = 0;
  int tests     = 0;
  int test_base = 0;  // error count when the running test began
  int cycles    = 0;

  // reference model
  logic              m_red;
  logic              m_green;
  logic              m_blue;
  byte_t             m_status;
  rgb_t              m_rgb;
  byte_t             m_rows [8];
  byte_t             m_ram [2**addr_w];
  logic [addr_w-1:0] m_addr;

  tb_clock #(
    .period_ns    (100),
    .reset_cycles (2)
  ) clock_i (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n)
  );

  trs_io_spi #(
    .addr_w (addr_w)
  ) dut_i (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .sck            (sck),
    .cs_n           (cs_n),
    .mosi           (mosi),
    .miso           (miso),
    .led_red        (led_red),
    .led_green      (led_green),
    .led_blue       (led_blue),
    .led_error      (led_error),
    .esp_status     (esp_status),
    .keyb_pressed   (keyb_pressed),
    .rgb            (rgb)
  );

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("timeout, run stopped after %0d clk cycles", cycles);
      $display("Test failed");
      $finish;
    end
  end

  task automatic check(input string name, input logic [23:0] got, input logic [23:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("MISMATCH %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic finish_test(input string name);
    tests++;
    if (errors == test_base)
      $display("%s: ok", name);
    else
      $display("%s: %0d errors", name, errors - test_base);
    test_base = errors;
  endtask

  task automatic wait_clk(input int n);
    repeat (n) @(posedge clk);
    #1;  // drive just after the edge
  endtask

  task automatic frame_start();
    cs_n = 1'b0;
    wait_clk(half_clk);
  endtask

  task automatic frame_end();
    cs_n = 1'b1;
    wait_clk(half_clk);
  endtask

  // one byte each way msb first with miso taken just before rising sck
  task automatic xfer(input byte_t tx, output byte_t rx);
    int   i;
    int   w;
    logic seen;
    seen = 1'b0;
    rx   = 8'h00;
    for (i = 7; i >= 0; i--) begin
      mosi = tx[i];
      wait_clk(half_clk);
      rx[i] = miso;
      sck   = 1'b1;
      for (w = 0; w < half_clk; w++) begin
        wait_clk(1);
        if (i == 0 && dut_i.rx_valid) seen = 1'b1;  // byte strobe
      end
      sck = 1'b0;
    end
    wait_clk(byte_gap);
    assert (seen) else begin
      $display("no rx_valid strobe after byte %h", tx);
      errors++;
    end
  endtask

  task automatic send_cmd(input byte_t code, input int n, input byte_t p0,
                          input byte_t p1, input byte_t p2);
    byte_t r;
    frame_start();
    xfer(code, r);
    if (n > 0) xfer(p0, r);
    if (n > 1) xfer(p1, r);
    if (n > 2) xfer(p2, r);
    frame_end();
  endtask

  // command then a dummy byte that carries the reply
  task automatic ask(input byte_t code, output byte_t reply);
    byte_t r;
    frame_start();
    xfer(code, r);
    xfer(8'h00, reply);
    frame_end();
  endtask

  task automatic check_regs();
    check("led_red", led_red, m_red);
    check("led_green", led_green, m_green);
    check("led_blue", led_blue, m_blue);
    check("esp_status", esp_status, m_status);
    check("rgb", rgb, m_rgb);
  endtask

  function automatic logic rows_or();
    logic any;
    any = 1'b0;
    for (int k = 0; k < 8; k++) any = any | (|m_rows[k]);
    return any;
  endfunction

  initial begin
    byte_t r;
    byte_t a;
    byte_t b;
    byte_t c;
    int    sel;
    int    i;
    sck      = 1'b0;
    cs_n     = 1'b1;
    mosi     = 1'b0;
    m_red    = 1'b0;
    m_green  = 1'b0;
    m_blue   = 1'b0;
    m_status = 8'h00;
    m_rgb    = 24'h000000;
    m_addr   = '0;
    for (i = 0; i < 8; i++) m_rows[i] = 8'h00;
    wait (cass_out_sel_n === 1'b1);
    wait_clk(2);

    ask(8'h00, r);  // get_cookie
    check("cookie reply", r, 8'haf);
    ask(8'h0f, r);  // get_version is major 0 minor 3
    check("version reply", r, 8'h03);
    finish_test("fixed replies");

    for (i = 0; i < 20; i++) begin
      sel = $unsigned($random(seed)) % 3;
      a   = $random(seed);
      b   = $random(seed);
      c   = $random(seed);
      if (sel == 0) begin
        send_cmd(8'd26, 1, a, 8'h00, 8'h00);
        m_red   = a[0];
        m_green = a[1];
        m_blue  = a[2];
      end else if (sel == 1) begin
        send_cmd(8'd32, 1, a, 8'h00, 8'h00);
        m_status = a;
      end else begin
        send_cmd(8'd17, 3, a, b, c);
        m_rgb = {a, b, c};  // first param is the high byte
      end
      check_regs();
    end
    finish_test("register commands");

    for (i = 0; i < 16; i++) begin
      a = $random(seed);  // row in the low 3 bits
      b = $random(seed);
      if (b[7]) b = 8'h00;  // release a row now and then
      send_cmd(8'd19, 2, a, b, 8'h00);
      m_rows[a[2:0]] = b;
      check("keyb_pressed", keyb_pressed, rows_or());
    end
    for (i = 0; i < 8; i++) begin
      send_cmd(8'd19, 2, 8'(i), 8'h00, 8'h00);
      m_rows[i] = 8'h00;
      check("keyb_pressed", keyb_pressed, rows_or());
    end
    check("keyb_pressed", keyb_pressed, 1'b0);
    finish_test("keyboard rows");

    a = $random(seed);  // address low byte
    b = $random(seed);
    send_cmd(8'd23, 2, a, b, 8'h00);
    m_addr = addr_w'({b, a});
    for (i = 0; i < 16; i++) begin
      c = $random(seed);
      send_cmd(8'd24, 1, c, 8'h00, 8'h00);
      m_ram[m_addr] = c;
      m_addr = m_addr + 1'b1;
    end
    send_cmd(8'd23, 2, a, b, 8'h00);  // back to the start
    m_addr = addr_w'({b, a});
    for (i = 0; i < 16; i++) begin
      ask(8'd25, r);
      check("peek reply", r, m_ram[m_addr]);
      m_addr = m_addr + 1'b1;
    end
    finish_test("display ram");

    frame_start();
    xfer(8'h00, r);  // get_cookie
    xfer(8'h7e, r);  // unknown code inside the reply slot
    frame_end();
    check("cookie reply", r, 8'haf);
    check("led_error", led_error, 1'b0);  // slot byte dropped
    send_cmd(8'h7e, 0, 8'h00, 8'h00, 8'h00);  // not a command code
    check("led_error", led_error, 1'b1);
    ask(8'h00, r);
    check("cookie reply", r, 8'haf);
    check_regs();
    finish_test("unknown code");

    a = $random(seed);
    b = $random(seed);
    frame_start();
    xfer(8'd17, r);
    xfer(a, r);
    xfer(b, r);
    frame_end();  // third colour byte never sent
    check_regs();
    c = $random(seed);
    send_cmd(8'd26, 1, c, 8'h00, 8'h00);
    m_red   = c[0];
    m_green = c[1];
    m_blue  = c[2];
    check_regs();
    send_cmd(8'd17, 3, c, a, b);
    m_rgb = {c, a, b};
    check_regs();
    finish_test("aborted command");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* trs_io_spi.f */
hdl/trs_io_pkg.sv
hdl/spi_slave.sv
hdl/cmd_decode.sv
hdl/cmd_execute.sv
hdl/reply_select.sv
hdl/trs_io_spi.sv
tests/tb_clock.sv
tests/trs_io_spi_assert.sv
tests/tb_trs_io_spi.sv

/* run.sh */
#!/usr/bin/env bash
# build the trs_io_spi testbench with verilator, run it, judge the log
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_trs_io_spi \
  -f trs_io_spi.f \
  || { echo "verilator build failed"; exit 1; }

./obj_dir/Vtb_trs_io_spi > sim.log 2>&1
cat sim.log

grep -q "Test completed successfully" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }
